/* cbc_core.f */
+incdir+include
source/cbc_pkg.sv
source/cbc_issue_stage.sv
source/cbc_chain_stage.sv
source/cbc_core.sv
bench/cbc_cipher_model.sv
bench/cbc_core_props.sv
bench/cbc_core_tb.sv

/* bench/cbc_core_tb.sv */
// CBC core testbench
// Directed tests of chaining, handshake and zeroize against a software model

`timescale 1ns/1ps

`include "cbc_config.svh"

module cbc_core_tb;

  localparam int TIMEOUT_CYCLES = 50;
  localparam int ROTATE_BITS    = 13;

  logic            clk = 1'b0;
  logic            reset_n;
  logic            zeroize;
  logic            next_cmd;
  logic            iv_load;
  cbc_pkg::mode_t  encdec;
  cbc_pkg::block_t iv;
  cbc_pkg::block_t block_msg;
  cbc_pkg::block_t result;
  logic            ready;
  logic            result_valid;
  logic            cipher_req;
  logic            cipher_dec;
  logic            cipher_done;
  cbc_pkg::block_t cipher_in;
  cbc_pkg::block_t cipher_out;

  int              check_count   = 0;
  int              error_count   = 0;
  int              timeout_count = 0;

  // Software chain and the blocks shared between the encrypt and decrypt tests
  cbc_pkg::block_t chain_model;
  cbc_pkg::block_t msgs [4];
  cbc_pkg::block_t cts [4];

  cbc_core DUT (
    .clk (clk), .reset_n (reset_n), .zeroize (zeroize),
    .encdec (encdec), .next_cmd (next_cmd), .ready (ready),
    .iv_load (iv_load), .iv (iv), .block_msg (block_msg),
    .result (result), .result_valid (result_valid),
    .cipher_req (cipher_req), .cipher_dec (cipher_dec), .cipher_in (cipher_in),
    .cipher_done (cipher_done), .cipher_out (cipher_out)
  );

  cbc_cipher_model engine (
    .clk (clk), .reset_n (reset_n), .cipher_req (cipher_req), .cipher_dec (cipher_dec),
    .cipher_in (cipher_in), .cipher_done (cipher_done), .cipher_out (cipher_out)
  );

  always #5 clk = ~clk;

  // ----------------------------------------------------------------------
  // Reference cipher and checks
  // ----------------------------------------------------------------------

  function automatic cbc_pkg::block_t ref_encrypt(cbc_pkg::block_t x);
    cbc_pkg::block_t t;
    t = x ^ engine.CIPHER_KEY;
    return (t << ROTATE_BITS) | (t >> (`CBC_BLOCK_W - ROTATE_BITS));
  endfunction

  function automatic cbc_pkg::block_t ref_decrypt(cbc_pkg::block_t x);
    cbc_pkg::block_t t;
    t = (x >> ROTATE_BITS) | (x << (`CBC_BLOCK_W - ROTATE_BITS));
    return t ^ engine.CIPHER_KEY;
  endfunction

  // Closing report, also the exit on a timeout
  task automatic finish_run();
    int prop_fails;
    prop_fails = DUT.u_props.violation_count;
    $display("Checks: %0d  mismatches: %0d  timeouts: %0d  assertion failures: %0d",
             check_count, error_count, timeout_count, prop_fails);
    if (error_count == 0 && timeout_count == 0 && prop_fails == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  endtask

  task automatic compare_block(string name, cbc_pkg::block_t got, cbc_pkg::block_t exp);
    check_count++;
    assert (got === exp)
    else
    begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    check_count++;
    assert (got === exp)
    else
    begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Bus actions
  // ----------------------------------------------------------------------

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!ready && cycles < TIMEOUT_CYCLES)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!ready)
    begin
      $display("Timeout: ready stayed low for %0d cycles", TIMEOUT_CYCLES);
      timeout_count++;
      finish_run();
    end
  endtask

  task automatic wait_result(output cbc_pkg::block_t got);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!result_valid && cycles < TIMEOUT_CYCLES)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!result_valid)
    begin
      $display("Timeout: no result_valid within %0d cycles", TIMEOUT_CYCLES);
      timeout_count++;
      finish_run();
    end
    else
      got = result;
  endtask

  // One-cycle pulse on iv_load or zeroize while the core is idle
  task automatic load_iv(cbc_pkg::block_t value);
    wait_ready();
    @(posedge clk);
    iv_load <= 1'b1;
    iv      <= value;
    @(posedge clk);
    iv_load <= 1'b0;
  endtask

  task automatic clear_chain();
    wait_ready();
    @(posedge clk);
    zeroize <= 1'b1;
    @(posedge clk);
    zeroize <= 1'b0;
  endtask

  // Send one command and check the request cycle that follows the accept
  // exp_in is the block the cipher should see
  task automatic start_block(cbc_pkg::mode_t mode, cbc_pkg::block_t msg,
                             cbc_pkg::block_t exp_in);
    wait_ready();
    @(posedge clk);
    next_cmd  <= 1'b1;
    encdec    <= mode;
    block_msg <= msg;
    @(posedge clk);
    next_cmd  <= 1'b0;
    @(negedge clk);
    compare_bit("ready", ready, 1'b0);
    compare_bit("cipher_req", cipher_req, 1'b1);
    compare_bit("cipher_dec", cipher_dec, mode == cbc_pkg::MODE_DEC);
    compare_block("cipher_in", cipher_in, exp_in);
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------

  task automatic check_reset_state();
    @(negedge clk);
    compare_bit("ready", ready, 1'b1);
    compare_bit("result_valid", result_valid, 1'b0);
    compare_bit("cipher_req", cipher_req, 1'b0);
  endtask

  // Each ciphertext becomes the chain of the next block
  task automatic encrypt_chain(cbc_pkg::block_t start_iv);
    cbc_pkg::block_t got;
    load_iv(start_iv);
    chain_model = start_iv;
    for (int i = 0; i < 4; i++)
    begin
      cts[i] = ref_encrypt(msgs[i] ^ chain_model);
      start_block(cbc_pkg::MODE_ENC, msgs[i], msgs[i] ^ chain_model);
      wait_result(got);
      compare_block("result", got, cts[i]);
      chain_model = cts[i];
    end
  endtask

  // Ciphertext goes to the cipher unchanged
  task automatic decrypt_chain(cbc_pkg::block_t start_iv);
    cbc_pkg::block_t got;
    cbc_pkg::block_t exp;
    load_iv(start_iv);
    chain_model = start_iv;
    for (int i = 0; i < 4; i++)
    begin
      exp = ref_decrypt(cts[i]) ^ chain_model;
      start_block(cbc_pkg::MODE_DEC, cts[i], cts[i]);
      wait_result(got);
      compare_block("result", got, exp);
      compare_block("plaintext", got, msgs[i]);
      chain_model = cts[i];
    end
  endtask

  // Keep next_cmd high with junk data for the two cycles where ready is low
  task automatic ignored_commands();
    cbc_pkg::block_t got;
    cbc_pkg::block_t exp;
    int              extra;
    exp = ref_encrypt(128'h0bad_cafe_1234_5678_9abc_def0_0f1e_2d3c ^ chain_model);
    wait_ready();
    @(posedge clk);
    next_cmd  <= 1'b1;
    encdec    <= cbc_pkg::MODE_ENC;
    block_msg <= 128'h0bad_cafe_1234_5678_9abc_def0_0f1e_2d3c;
    @(posedge clk);
    block_msg <= 128'hdead_0001_dead_0002_dead_0003_dead_0004;
    @(posedge clk);
    block_msg <= 128'hdead_0005_dead_0006_dead_0007_dead_0008;
    @(posedge clk);
    next_cmd  <= 1'b0;
    wait_result(got);
    compare_block("result", got, exp);
    chain_model = exp;
    extra = 0;
    repeat (15)
    begin
      @(negedge clk);
      if (result_valid)
        extra++;
    end
    check_count++;
    assert (extra == 0)
    else
    begin
      $display("Ignored commands produced %0d extra results", extra);
      error_count++;
    end
    // Chain must still be the one accepted ciphertext
    exp = ref_encrypt(msgs[0] ^ chain_model);
    start_block(cbc_pkg::MODE_ENC, msgs[0], msgs[0] ^ chain_model);
    wait_result(got);
    compare_block("result", got, exp);
  endtask

  task automatic zeroize_chain();
    cbc_pkg::block_t got;
    cbc_pkg::block_t exp;
    load_iv(128'hffff_0000_ffff_0000_1111_2222_3333_4444);
    clear_chain();
    chain_model = `CBC_CHAIN_RESET;
    exp = ref_encrypt(msgs[1] ^ chain_model);
    start_block(cbc_pkg::MODE_ENC, msgs[1], msgs[1] ^ chain_model);
    wait_result(got);
    compare_block("result", got, exp);
  endtask

  initial
  begin
    reset_n   = 1'b0;
    zeroize   = 1'b0;
    next_cmd  = 1'b0;
    iv_load   = 1'b0;
    encdec    = cbc_pkg::MODE_ENC;
    iv        = '0;
    block_msg = '0;
    msgs[0] = 128'h6bc1_bee2_2e40_9f96_e93d_7e11_7393_172a;
    msgs[1] = 128'hae2d_8a57_1e03_ac9c_9eb7_6fac_45af_8e51;
    msgs[2] = 128'h30c8_1c46_a35c_e411_e5fb_c119_1a0a_52ef;
    msgs[3] = 128'hf69f_2445_df4f_9b17_ad2b_417b_e66c_3710;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);
    check_reset_state();
    encrypt_chain(128'h0001_0203_0405_0607_0809_0a0b_0c0d_0e0f);
    decrypt_chain(128'h0001_0203_0405_0607_0809_0a0b_0c0d_0e0f);
    ignored_commands();
    zeroize_chain();
    repeat (3) @(posedge clk);
    finish_run();
  end

endmodule

/* bench/cbc_core_props.sv */
// CBC core handshake properties
// Bound into the core to watch the command and cipher handshakes

`timescale 1ns/1ps

module cbc_core_props (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  next_cmd,
  input  logic  iv_load,
  input  logic  ready,
  input  logic  cipher_req,
  input  logic  cipher_done,
  input  logic  result_valid
);

  // Violations so far, read back by the testbench top
  int violation_count = 0;

  // ----------------------------------------------------------------------
  // Cipher handshake
  // ----------------------------------------------------------------------

  // One request per accepted block
  req_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    cipher_req |=> !cipher_req)
  else
  begin
    $error("cipher_req lasted more than one cycle");
    violation_count++;
  end

  // Result one cycle after the engine finishes, and never without it
  valid_after_done: assert property (@(posedge clk) disable iff (!reset_n)
    result_valid == $past(cipher_done))
  else
  begin
    $error("result_valid does not follow cipher_done by one cycle");
    violation_count++;
  end

  // Never ready while a request is going out
  no_ready_with_req: assert property (@(posedge clk) disable iff (!reset_n)
    !(ready && cipher_req))
  else
  begin
    $error("ready and cipher_req high together");
    violation_count++;
  end

  // ----------------------------------------------------------------------
  // Command and reset rules
  // ----------------------------------------------------------------------

  iv_not_with_cmd: assert property (@(posedge clk) disable iff (!reset_n)
    !(iv_load && next_cmd))
  else
  begin
    $error("iv_load and next_cmd in the same cycle");
    violation_count++;
  end

  // Idle and quiet right after reset release
  reset_state: assert property (@(posedge clk)
    $rose(reset_n) |-> (ready && !result_valid && !cipher_req))
  else
  begin
    $error("core not idle after reset");
    violation_count++;
  end

endmodule

bind cbc_core cbc_core_props u_props (
  .clk          (clk),
  .reset_n      (reset_n),
  .next_cmd     (next_cmd),
  .iv_load      (iv_load),
  .ready        (ready),
  .cipher_req   (cipher_req),
  .cipher_done  (cipher_done),
  .result_valid (result_valid)
);

/* bench/cbc_cipher_model.sv */
// Behavioural block cipher engine for the CBC core testbench
// Keyed rotate with a random latency behind the req/done handshake

`timescale 1ns/1ps

`include "cbc_config.svh"

module cbc_cipher_model (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             cipher_req,
  input  logic             cipher_dec,
  input  cbc_pkg::block_t  cipher_in,
  output logic             cipher_done,
  output cbc_pkg::block_t  cipher_out
);

  // ----------------------------------------------------------------------
  // Cipher function
  // ----------------------------------------------------------------------

  localparam cbc_pkg::block_t CIPHER_KEY = 128'h3c6e_f372_a54f_f53a_510e_527f_9b05_688c;
  localparam int ROT_BITS    = 13;
  localparam int MAX_LATENCY = 6;

  // Whiten with the key, then rotate left
  function automatic cbc_pkg::block_t encrypt_block(cbc_pkg::block_t x);
    cbc_pkg::block_t t;
    t = x ^ CIPHER_KEY;
    return (t << ROT_BITS) | (t >> (`CBC_BLOCK_W - ROT_BITS));
  endfunction

  // Rotate right, then remove the key
  function automatic cbc_pkg::block_t decrypt_block(cbc_pkg::block_t x);
    cbc_pkg::block_t t;
    t = (x >> ROT_BITS) | (x << (`CBC_BLOCK_W - ROT_BITS));
    return t ^ CIPHER_KEY;
  endfunction

  // ----------------------------------------------------------------------
  // Engine with random latency, 1 to MAX_LATENCY cycles
  // ----------------------------------------------------------------------

  initial
  begin
    int              latency;
    int              remaining;
    logic            busy;
    cbc_pkg::block_t held;
    void'($urandom(90));
    busy        = 1'b0;
    remaining   = 0;
    held        = '0;
    cipher_done = 1'b0;
    cipher_out  = '0;
    forever
    begin
      @(posedge clk or negedge reset_n);
      if (!reset_n)
      begin
        busy        = 1'b0;
        cipher_done <= 1'b0;
        cipher_out  <= '0;
      end
      else
      begin
        // Done is a single-cycle pulse
        cipher_done <= 1'b0;
        if (cipher_req && !busy)
        begin
          latency = 1 + ($urandom % MAX_LATENCY);
          held    = cipher_dec ? decrypt_block(cipher_in) : encrypt_block(cipher_in);
          if (latency == 1)
          begin
            cipher_done <= 1'b1;
            cipher_out  <= held;
          end
          else
          begin
            busy      = 1'b1;
            remaining = latency - 1;
          end
        end
        else if (busy)
        begin
          remaining = remaining - 1;
          if (remaining == 0)
          begin
            busy        = 1'b0;
            cipher_done <= 1'b1;
            cipher_out  <= held;
          end
        end
      end
    end
  end

endmodule

/* source/cbc_core.sv */
// CBC chaining core
// Issue and chain stages around an external block cipher engine

`timescale 1ns/1ps

module cbc_core (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             zeroize,

  // Control
  input  cbc_pkg::mode_t   encdec,
  input  logic             next_cmd,
  output logic             ready,

  // Data
  input  logic             iv_load,
  input  cbc_pkg::block_t  iv,
  input  cbc_pkg::block_t  block_msg,
  output cbc_pkg::block_t  result,
  output logic             result_valid,

  // External cipher engine
  output logic             cipher_req,
  output logic             cipher_dec,
  output cbc_pkg::block_t  cipher_in,
  input  logic             cipher_done,
  input  cbc_pkg::block_t  cipher_out
);

  // ----------------------------------------------------------------------
  // Stage links
  // ----------------------------------------------------------------------

  cbc_pkg::mode_t  issue_mode;
  cbc_pkg::block_t issue_block;
  cbc_pkg::block_t chain;
  logic            block_done;

  // Command accept and cipher input forming
  cbc_issue_stage u_issue (
    .clk         (clk),
    .reset_n     (reset_n),
    .next_cmd    (next_cmd),
    .encdec      (encdec),
    .block_msg   (block_msg),
    .ready       (ready),
    .chain       (chain),
    .block_done  (block_done),
    .cipher_req  (cipher_req),
    .cipher_dec  (cipher_dec),
    .cipher_in   (cipher_in),
    .issue_mode  (issue_mode),
    .issue_block (issue_block)
  );

  // Output chaining and chain register
  cbc_chain_stage u_chain (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize      (zeroize),
    .iv_load      (iv_load),
    .iv           (iv),
    .cipher_done  (cipher_done),
    .cipher_out   (cipher_out),
    .issue_mode   (issue_mode),
    .issue_block  (issue_block),
    .chain        (chain),
    .block_done   (block_done),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

/* source/cbc_chain_stage.sv */
// CBC chain stage
// Applies output chaining, owns the chain register and drives the result pulse

`timescale 1ns/1ps

`include "cbc_config.svh"

module cbc_chain_stage (
  input  logic             clk,
  input  logic             reset_n,

  // Chain control
  input  logic             zeroize,
  input  logic             iv_load,
  input  cbc_pkg::block_t  iv,

  // Cipher completion
  input  logic             cipher_done,
  input  cbc_pkg::block_t  cipher_out,

  // From the issue stage
  input  cbc_pkg::mode_t   issue_mode,
  input  cbc_pkg::block_t  issue_block,

  // To the issue stage
  output cbc_pkg::block_t  chain,
  output logic             block_done,

  // Result port
  output cbc_pkg::block_t  result,
  output logic             result_valid
);

  // ----------------------------------------------------------------------
  // Internal state
  // ----------------------------------------------------------------------

  cbc_pkg::block_t chain_q;
  cbc_pkg::block_t chain_next;
  logic            chain_we;

  cbc_pkg::block_t result_q;
  cbc_pkg::block_t result_next;
  logic            valid_q;

  logic            is_enc;

  assign is_enc = (issue_mode == cbc_pkg::MODE_ENC);

  // ----------------------------------------------------------------------
  // Output chaining
  // ----------------------------------------------------------------------

  // Encrypt result is the cipher output itself
  // Decrypt result is unwhitened with the chain of the previous block
  always_comb
  begin
    if (is_enc)
      result_next = cipher_out;
    else
      result_next = cipher_out ^ chain_q;
  end

  // ----------------------------------------------------------------------
  // Chain update
  // ----------------------------------------------------------------------

  // Priority: zeroize, IV load, then the block just finished
  // zeroize and iv_load only arrive while idle, so they never meet
  // a cipher_done in practice, the order still keeps it defined
  always_comb
  begin
    chain_we   = 1'b0;
    chain_next = chain_q;
    if (zeroize)
    begin
      chain_we   = 1'b1;
      chain_next = `CBC_CHAIN_RESET;
    end
    else if (iv_load)
    begin
      chain_we   = 1'b1;
      chain_next = iv;
    end
    else if (cipher_done)
    begin
      chain_we = 1'b1;
      // Ciphertext always becomes the next chain
      if (is_enc)
        chain_next = cipher_out;
      else
        chain_next = issue_block;
    end
  end

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      chain_q <= `CBC_CHAIN_RESET;
      valid_q <= 1'b0;
    end
    else
    begin
      if (chain_we)
        chain_q <= chain_next;
      // One-cycle pulse, one cycle after cipher_done
      valid_q <= cipher_done;
    end
  end

  // Result data, cleared on zeroize so no plaintext lingers
  always_ff @(posedge clk)
  begin
    if (zeroize)
      result_q <= `CBC_CHAIN_RESET;
    else if (cipher_done)
      result_q <= result_next;
  end

  assign chain        = chain_q;
  assign result       = result_q;
  // Same register seen under two names
  assign result_valid = valid_q;
  assign block_done   = valid_q;

endmodule

/* source/cbc_issue_stage.sv */
// CBC issue stage
// Accepts block commands, forms the cipher input and tracks the busy/ready state

`timescale 1ns/1ps

module cbc_issue_stage (
  input  logic             clk,
  input  logic             reset_n,

  // Command side
  input  logic             next_cmd,
  input  cbc_pkg::mode_t   encdec,
  input  cbc_pkg::block_t  block_msg,
  output logic             ready,

  // From the chain stage
  input  cbc_pkg::block_t  chain,
  input  logic             block_done,

  // Cipher request
  output logic             cipher_req,
  output logic             cipher_dec,
  output cbc_pkg::block_t  cipher_in,

  // To the chain stage
  output cbc_pkg::mode_t   issue_mode,
  output cbc_pkg::block_t  issue_block
);

  // ----------------------------------------------------------------------
  // Internal state
  // ----------------------------------------------------------------------

  cbc_pkg::stage_state_t state;
  cbc_pkg::stage_state_t state_next;

  // Command taken on this edge
  logic                  accept;

  logic                  req_q;
  cbc_pkg::mode_t        mode_q;
  cbc_pkg::block_t       block_q;
  cbc_pkg::block_t       cipher_in_q;

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------

  // Idle, or the block in flight is being delivered right now
  // The delivery cycle already sees the updated chain, so a new block
  // may be taken back-to-back
  assign ready  = (state == cbc_pkg::ST_IDLE) || block_done;
  assign accept = next_cmd && ready;

  always_comb
  begin
    state_next = state;
    case (state)
      cbc_pkg::ST_IDLE:
      begin
        if (accept)
          state_next = cbc_pkg::ST_BUSY;
      end
      cbc_pkg::ST_BUSY:
      begin
        // Back-to-back command keeps the stage busy
        if (accept)
          state_next = cbc_pkg::ST_BUSY;
        else if (block_done)
          state_next = cbc_pkg::ST_IDLE;
      end
      default:
      begin
        state_next = cbc_pkg::ST_IDLE;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state  <= cbc_pkg::ST_IDLE;
      req_q  <= 1'b0;
      mode_q <= cbc_pkg::MODE_ENC;
    end
    else
    begin
      state <= state_next;
      // Single-cycle request, one per accepted command
      req_q <= accept;
      if (accept)
        mode_q <= encdec;
    end
  end

  // ----------------------------------------------------------------------
  // Block registers
  // ----------------------------------------------------------------------

  // Encrypt pre-whitens the message with the chain
  // Decrypt sends the ciphertext as is and keeps it for the next chain
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      block_q <= block_msg;
      if (encdec == cbc_pkg::MODE_ENC)
        cipher_in_q <= block_msg ^ chain;
      else
        cipher_in_q <= block_msg;
    end
  end

  assign cipher_req  = req_q;
  assign cipher_dec  = (mode_q == cbc_pkg::MODE_DEC);
  assign cipher_in   = cipher_in_q;
  assign issue_mode  = mode_q;
  assign issue_block = block_q;

endmodule

/* source/cbc_pkg.sv */
// CBC core types
// Block, mode and stage state types used by both pipeline stages

`include "cbc_config.svh"

package cbc_pkg;

  // ----------------------------------------------------------------------
  // Data
  // ----------------------------------------------------------------------

  // One data block as it moves between the stages and the cipher
  typedef logic [`CBC_BLOCK_W-1:0] block_t;

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------

  // Cipher direction, same polarity as encdec on the port
  // High selects encrypt
  typedef enum logic {
    MODE_DEC = 1'b0,
    MODE_ENC = 1'b1
  } mode_t;

  // Two-state machine used by each stage
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_BUSY = 1'b1
  } stage_state_t;

endpackage

/* include/cbc_config.svh */
// CBC core configuration
// Block width and chain register reset value shared by the RTL and the testbench

`ifndef CBC_CONFIG_SVH
`define CBC_CONFIG_SVH

// ----------------------------------------------------------------------
// Datapath sizing
// ----------------------------------------------------------------------

// One cipher block, in bits
`define CBC_BLOCK_W 128

// ----------------------------------------------------------------------
// Chain register
// ----------------------------------------------------------------------

// Value after reset and after zeroize
// All zeros, so a session without an IV load starts from a known chain
`define CBC_CHAIN_RESET {`CBC_BLOCK_W{1'b0}}

`endif
